/* bench/ie_stimulus.txt */
// type idtr_base eip eflags cs stall_mask, one event per line
// mask bit k stalls the k-th packet cycle of the event
1 00010000 c0001234 00000202 00000008 00000000
2 00010000 c0005678 00000246 00000010 00000000
4 00020000 0040abcd 00003202 0000001b 00000000
3 00010000 c0001234 00000202 00000008 00000000
6 00010000 c0009abc 00000002 00000023 00000000
7 00030000 80000000 0003ffff 0000ffff 00000000
5 fffffff0 12345678 00020001 00001234 00000000
1 00010000 c0001234 00000202 00000008 00000005
4 00040000 00401000 00000213 0000001b 00000601
2 00050000 deadbeef 00000a82 00000073 0000ffff
6 00060800 00000000 00000000 00000000 00000a0a

/* tb.f */
logic/ie_pkg.sv
logic/ie_ctx_if.sv
logic/ie_vector_calc.sv
logic/ie_sequencer.sv
logic/ie_packet_builder.sv
logic/ie_handler.sv
bench/ie_checker.sv
bench/tb_ie_handler.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := tb_ie_handler
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_ie_handler.sv */
`timescale 1ns/1ps

module tb_ie_handler;

    localparam logic [7:0] PROT_VEC = 8'd32;
    localparam logic [7:0] PAGE_VEC = 8'd46;
    localparam logic [7:0] INTR_VEC = 8'd81;
    localparam int         LIMIT    = 400;  // cycles per wait

    logic clk = 1'b0;
    logic arst_n, enable, ie_in, is_iretd, rrag_stall, is_final_switch_wb, quiet_done;
    logic [2:0]   ie_type;
    logic [31:0]  idtr_base, eip_wb;
    logic [17:0]  eflags_wb;
    logic [15:0]  cs_wb, stall_mask;
    logic [127:0] packet_out;
    logic packet_out_select, flush_pipe, ptc_clear, ld_eip, is_pop_eflags;
    logic is_servicing, is_switching, ld_info_regs, invalidate_fetch;
    logic [31:0] stim [0:95];  // six words per event
    logic [31:0] lfsr;
    logic [6:0]  ptr;
    logic [4:0]  pkt_k;        // packet cycle counter for the stall mask
    logic [1:0]  delay_left;
    logic        in_wait, answered;
    bit          ev_ok, timed_out;
    int          n_ev, err_count, evt_count;

    always #2 clk = ~clk;

    ie_handler #(.PROT_VECTOR(PROT_VEC), .PAGE_VECTOR(PAGE_VEC), .INTR_VECTOR(INTR_VEC)) u_dut (
        .clk(clk), .arst_n(arst_n), .enable(enable), .ie_in(ie_in), .ie_type(ie_type),
        .idtr_base(idtr_base), .eip_wb(eip_wb), .eflags_wb(eflags_wb), .cs_wb(cs_wb),
        .is_iretd(is_iretd), .rrag_stall(rrag_stall), .is_final_switch_wb(is_final_switch_wb),
        .packet_out(packet_out), .packet_out_select(packet_out_select),
        .flush_pipe(flush_pipe), .ptc_clear(ptc_clear), .ld_eip(ld_eip),
        .is_pop_eflags(is_pop_eflags), .is_servicing(is_servicing),
        .is_switching(is_switching), .ld_info_regs(ld_info_regs),
        .invalidate_fetch(invalidate_fetch)
    );

    ie_checker #(.PROT_VECTOR(PROT_VEC), .PAGE_VECTOR(PAGE_VEC), .INTR_VECTOR(INTR_VEC)) u_checker (
        .clk(clk), .arst_n(arst_n), .enable(enable), .ie_in(ie_in), .ie_type(ie_type),
        .idtr_base(idtr_base), .eip_wb(eip_wb), .eflags_wb(eflags_wb), .cs_wb(cs_wb),
        .is_iretd(is_iretd), .rrag_stall(rrag_stall), .is_final_switch_wb(is_final_switch_wb),
        .packet_out(packet_out), .packet_out_select(packet_out_select),
        .flush_pipe(flush_pipe), .ptc_clear(ptc_clear), .ld_eip(ld_eip),
        .is_pop_eflags(is_pop_eflags), .is_servicing(is_servicing),
        .is_switching(is_switching), .ld_info_regs(ld_info_regs),
        .invalidate_fetch(invalidate_fetch), .quiet_done(quiet_done),
        .err_count(err_count), .evt_count(evt_count)
    );

    // galois form with taps x^32+x^30+x^26+x^25+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // back end model with a stall mask per packet cycle and a final switch 0..3 cycles late
    always @(posedge clk) begin
        #0.5;
        rrag_stall         = 1'b0;
        is_final_switch_wb = 1'b0;
        if (packet_out_select && !invalidate_fetch) begin
            rrag_stall = pkt_k[4] ? 1'b0 : stall_mask[pkt_k[3:0]];
            if (!pkt_k[4])
                pkt_k = pkt_k + 5'd1;
        end
        if (invalidate_fetch && !in_wait) begin
            in_wait       = 1'b1;
            delay_left[0] = lfsr[0];
            lfsr          = lfsr_next(lfsr);
            delay_left[1] = lfsr[0];
            lfsr          = lfsr_next(lfsr);
        end
        if (in_wait && !answered) begin
            if (delay_left == 2'd0) begin
                is_final_switch_wb = 1'b1;
                answered           = 1'b1;
            end else begin
                delay_left = delay_left - 2'd1;
            end
        end
        if (!invalidate_fetch) begin
            in_wait  = 1'b0;
            answered = 1'b0;
        end
    end

    task automatic step;
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_service(output bit ok);
        int n;
        n = 0;
        while (!(is_servicing && !is_switching) && n < LIMIT) begin
            step();
            n++;
        end
        ok = is_servicing && !is_switching;
        if (!ok)
            $display("timeout: sequencer never reached the service state");
    endtask

    task automatic wait_idle(output bit ok);
        int n;
        n = 0;
        while (!(ld_info_regs && !is_servicing) && n < LIMIT) begin
            step();
            n++;
        end
        ok = ld_info_regs && !is_servicing;
        if (!ok)
            $display("timeout: sequencer never returned to idle");
    endtask

    task automatic run_event(input logic [6:0] p, output bit ok);
        step();
        ie_type    = stim[p][2:0];
        idtr_base  = stim[p+7'd1];
        eip_wb     = stim[p+7'd2];
        eflags_wb  = stim[p+7'd3][17:0];
        cs_wb      = stim[p+7'd4][15:0];
        stall_mask = stim[p+7'd5][15:0];
        pkt_k      = 5'd0;
        ie_in      = 1'b1;
        step();
        ie_in = 1'b0;
        wait_service(ok);
        if (ok) begin
            is_iretd = 1'b1;  // handler done
            step();
            is_iretd = 1'b0;
            wait_idle(ok);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        enable = 1'b1;
        {ie_in, is_iretd, rrag_stall, is_final_switch_wb, quiet_done} = '0;
        ie_type    = '0;
        idtr_base  = '0;
        eip_wb     = '0;
        eflags_wb  = '0;
        cs_wb      = '0;
        stall_mask = '0;
        pkt_k      = '0;
        delay_left = '0;
        in_wait    = 1'b0;
        answered   = 1'b0;
        ev_ok      = 1'b1;
        timed_out  = 1'b0;
        lfsr       = 32'hbef5_4d6d;
        n_ev       = 0;
        for (int i = 0; i < 96; i++)
            stim[i] = 32'hffff_ffff;  // end marker
        $readmemh("bench/ie_stimulus.txt", stim);
        repeat (4) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        ptr = 7'd0;
        while (!timed_out && ptr < 7'd96 && stim[ptr] != 32'hffff_ffff) begin
            run_event(ptr, ev_ok);
            timed_out = !ev_ok;
            ptr = ptr + 7'd6;
            n_ev++;
        end
        if (!timed_out) begin
            // ie_in with enable low must be ignored
            step();
            enable = 1'b0;
            ie_in  = 1'b1;
            step();
            ie_in = 1'b0;
            repeat (20) step();
            quiet_done = 1'b1;
            step();
            quiet_done = 1'b0;
            enable     = 1'b1;
            repeat (2) step();
        end
        $display("tests %0d, events %0d of %0d, errors %0d", evt_count + 1, evt_count, n_ev,
                 err_count);
        if (err_count == 0 && evt_count == n_ev && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            if (evt_count != n_ev)
                $display("checker saw %0d events but %0d were sent", evt_count, n_ev);
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* bench/ie_checker.sv */
`timescale 1ns/1ps

module ie_checker #(
    parameter logic [7:0] PROT_VECTOR = 8'd13,
    parameter logic [7:0] PAGE_VECTOR = 8'd14,
    parameter logic [7:0] INTR_VECTOR = 8'd15
) (
    input  logic clk, arst_n, enable, ie_in, is_iretd, rrag_stall, is_final_switch_wb,
    input  logic [2:0]   ie_type,
    input  logic [31:0]  idtr_base, eip_wb,
    input  logic [17:0]  eflags_wb,
    input  logic [15:0]  cs_wb,
    input  logic [127:0] packet_out,
    input  logic packet_out_select, flush_pipe, ptc_clear, ld_eip, is_pop_eflags,
    input  logic is_servicing, is_switching, ld_info_regs, invalidate_fetch, quiet_done,
    output int   err_count,
    output int   evt_count
);
    localparam int P_IDLE = 0, P_FLUSH_IN = 1, P_ENTRY = 2, P_WAIT_IN = 3;
    localparam int P_SERVICE = 4, P_FLUSH_OUT = 5, P_EXIT = 6, P_WAIT_OUT = 7;

    int           phase;
    int           ev_err;
    logic [3:0]   idx;         // index into the expected packet list
    logic         fin_q;
    logic [2:0]   ev_type;
    logic [127:0] exp_pkt [0:10];
    logic [31:0]  gate;

    // prefix bytes first and the immediate after them lowest byte first
    function automatic logic [127:0] encode(input logic [23:0] prefix, input int plen,
                                            input logic [31:0] imm, input bit has_imm);
        logic [127:0] p;
        logic [31:0]  le;
        le = {imm[7:0], imm[15:8], imm[23:16], imm[31:24]};
        p  = {104'b0, prefix} << (128 - 8 * plen);
        if (has_imm)
            p = p | ({96'b0, le} << (96 - 8 * plen));
        return p;
    endfunction

    function automatic logic [7:0] pick_vector(input logic [2:0] t);
        if (t[0])
            return PROT_VECTOR;
        if (t[1])
            return PAGE_VECTOR;
        return t[2] ? INTR_VECTOR : 8'd0;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            err_count++;
            ev_err++;
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase     = P_IDLE;
            idx       = 4'd0;
            fin_q     = 1'b0;
            ev_err    = 0;
            err_count = 0;
            evt_count = 0;
        end else begin
            check_bit("flush_pipe", flush_pipe, phase == P_FLUSH_IN || phase == P_FLUSH_OUT);
            check_bit("ptc_clear", ptc_clear, phase == P_FLUSH_IN || phase == P_FLUSH_OUT);
            check_bit("packet_out_select", packet_out_select, phase == P_ENTRY ||
                      phase == P_WAIT_IN || phase == P_EXIT || phase == P_WAIT_OUT);
            check_bit("invalidate_fetch", invalidate_fetch,
                      phase == P_WAIT_IN || phase == P_WAIT_OUT);
            check_bit("ld_eip", ld_eip, phase == P_IDLE || phase == P_SERVICE);
            check_bit("ld_info_regs", ld_info_regs, phase == P_IDLE);
            check_bit("is_servicing", is_servicing, phase != P_IDLE && phase != P_FLUSH_IN);
            check_bit("is_switching", is_switching, phase != P_IDLE && phase != P_SERVICE);
            check_bit("is_pop_eflags", is_pop_eflags, phase == P_EXIT && idx == 4'd10);
            if ((phase == P_ENTRY || phase == P_EXIT) && packet_out !== exp_pkt[idx]) begin
                $display("[ERROR] %0t packet_out got %h expected %h", $time, packet_out,
                         exp_pkt[idx]);
                err_count++;
                ev_err++;
            end
            if (quiet_done) begin
                $display("enable-low test: %s", ev_err == 0 ? "pass" : "FAIL");
                ev_err = 0;
            end
            case (phase)
                P_IDLE: begin
                    // context tracks the writeback inputs until the event starts
                    gate        = idtr_base + {21'b0, pick_vector(ie_type), 3'b000};
                    ev_type     = ie_type;
                    exp_pkt[0]  = encode(24'h68, 1, {16'b0, cs_wb}, 1'b1);
                    exp_pkt[1]  = encode(24'h68, 1, eip_wb, 1'b1);
                    exp_pkt[2]  = encode(24'h68, 1, {14'b0, eflags_wb}, 1'b1);
                    exp_pkt[3]  = encode(24'h8b0d, 2, gate, 1'b1);
                    exp_pkt[4]  = encode(24'h8b15, 2, gate + 32'd4, 1'b1);
                    exp_pkt[5]  = encode(24'h6687d1, 3, 32'b0, 1'b0);
                    exp_pkt[6]  = encode(24'hc1f904, 3, 32'b0, 1'b0);
                    exp_pkt[7]  = encode(24'h668ec9, 3, 32'b0, 1'b0);
                    exp_pkt[8]  = encode(24'hffe2, 2, 32'b0, 1'b0);
                    exp_pkt[9]  = encode(24'hcb, 1, 32'b0, 1'b0);
                    exp_pkt[10] = encode(24'h59, 1, 32'b0, 1'b0);
                    if (enable && ie_in)
                        phase = P_FLUSH_IN;
                end
                P_FLUSH_IN: begin
                    phase = P_ENTRY;
                    idx   = 4'd0;
                end
                P_ENTRY, P_EXIT: begin
                    if (!rrag_stall)
                        idx = idx + 4'd1;  // stalled cycles repeat the packet
                    if (idx == 4'd9 && phase == P_ENTRY)
                        phase = P_WAIT_IN;
                    else if (idx == 4'd11)
                        phase = P_WAIT_OUT;
                end
                P_WAIT_IN: if (fin_q) phase = P_SERVICE;
                P_SERVICE: if (is_iretd) phase = P_FLUSH_OUT;
                P_FLUSH_OUT: phase = P_EXIT;
                P_WAIT_OUT: begin
                    if (fin_q) begin
                        phase = P_IDLE;
                        evt_count++;
                        $display("event %0d type %0h gate %h: %s", evt_count, ev_type, gate,
                                 ev_err == 0 ? "pass" : "FAIL");
                        ev_err = 0;
                    end
                end
                default: phase = P_IDLE;
            endcase
            fin_q = is_final_switch_wb;  // registered in the DUT too
        end
    end

endmodule

/* logic/ie_handler.sv */
`timescale 1ns/1ps

module ie_handler #(
    parameter ie_pkg::vector_t PROT_VECTOR = ie_pkg::DEF_PROT_VECTOR,
    parameter ie_pkg::vector_t PAGE_VECTOR = ie_pkg::DEF_PAGE_VECTOR,
    parameter ie_pkg::vector_t INTR_VECTOR = ie_pkg::DEF_INTR_VECTOR
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             enable,
    input  logic             ie_in,               // event strobe from wb
    input  ie_pkg::ie_type_t ie_type,
    input  ie_pkg::addr_t    idtr_base,
    input  ie_pkg::addr_t    eip_wb,
    input  ie_pkg::eflags_t  eflags_wb,
    input  ie_pkg::sel_t     cs_wb,
    input  logic             is_iretd,
    input  logic             rrag_stall,
    input  logic             is_final_switch_wb,
    output ie_pkg::packet_t  packet_out,
    output logic             packet_out_select,   // fetch mux picks packet over ibuf
    output logic             flush_pipe,
    output logic             ptc_clear,
    output logic             ld_eip,
    output logic             is_pop_eflags,
    output logic             is_servicing,
    output logic             is_switching,
    output logic             ld_info_regs,
    output logic             invalidate_fetch
);
    import ie_pkg::*;

    ie_state_t state;

    ie_ctx_if ctx_if ();

    ie_vector_calc #(
        .PROT_VECTOR (PROT_VECTOR),
        .PAGE_VECTOR (PAGE_VECTOR),
        .INTR_VECTOR (INTR_VECTOR)
    ) u_vector_calc (
        .clk          (clk),
        .arst_n       (arst_n),
        .ie_type      (ie_type),
        .idtr_base    (idtr_base),
        .eip_wb       (eip_wb),
        .eflags_wb    (eflags_wb),
        .cs_wb        (cs_wb),
        .ld_info_regs (ld_info_regs),
        .ctx          (ctx_if.source)
    );

    ie_sequencer u_sequencer (
        .clk                (clk),
        .arst_n             (arst_n),
        .enable             (enable),
        .ie_in              (ie_in),
        .is_iretd           (is_iretd),
        .rrag_stall         (rrag_stall),
        .is_final_switch_wb (is_final_switch_wb),
        .state              (state),
        .ld_info_regs       (ld_info_regs),
        .packet_out_select  (packet_out_select),
        .flush_pipe         (flush_pipe),
        .ptc_clear          (ptc_clear),
        .ld_eip             (ld_eip),
        .is_pop_eflags      (is_pop_eflags),
        .is_servicing       (is_servicing),
        .is_switching       (is_switching),
        .invalidate_fetch   (invalidate_fetch)
    );

    ie_packet_builder u_packet_builder (
        .state      (state),
        .ctx        (ctx_if.sink),
        .packet_out (packet_out)
    );

endmodule

/* logic/ie_packet_builder.sv */
`timescale 1ns/1ps

module ie_packet_builder (
    input  ie_pkg::ie_state_t state,
    ie_ctx_if.sink            ctx,
    output ie_pkg::packet_t   packet_out
);
    import ie_pkg::*;

    addr_t cs_imm;
    addr_t eflags_imm;

    // immediates go little-endian into the byte stream
    function automatic addr_t swap32(input addr_t val);
        return {val[7:0], val[15:8], val[23:16], val[31:24]};
    endfunction

    assign cs_imm     = {{(ADDR_W-SEL_W){1'b0}}, ctx.cs};
    assign eflags_imm = {{(ADDR_W-EFLAGS_W){1'b0}}, ctx.eflags};

    always_comb begin
        case (state)
            PUSH_CS: begin
                packet_out = {OP_PUSH_IMM, swap32(cs_imm), 88'b0};
            end
            PUSH_EIP: begin
                packet_out = {OP_PUSH_IMM, swap32(ctx.eip), 88'b0};
            end
            PUSH_EFLAGS: begin
                packet_out = {OP_PUSH_IMM, swap32(eflags_imm), 88'b0};
            end
            LOAD_LO: begin
                packet_out = {OP_MOV_ECX, swap32(ctx.idt_entry), 80'b0};   // gate low dword
            end
            LOAD_HI: begin
                packet_out = {OP_MOV_EDX, swap32(ctx.idt_entry4), 80'b0};  // gate high dword
            end
            XCHG:       packet_out = {OP_XCHG, 104'b0};
            SAR:        packet_out = {OP_SAR, 104'b0};
            MOV_CS:     packet_out = {OP_MOV_CS, 104'b0};
            JMP:        packet_out = {OP_JMP, 112'b0};  // into the handler
            RET_FAR:    packet_out = {OP_RET_FAR, 120'b0};
            POP_EFLAGS: packet_out = {OP_POP, 120'b0};  // pops ecx for the back end to route to eflags
            default:    packet_out = '0;
        endcase
    end

endmodule

/* logic/ie_sequencer.sv */
`timescale 1ns/1ps

module ie_sequencer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              enable,
    input  logic              ie_in,
    input  logic              is_iretd,
    input  logic              rrag_stall,
    input  logic              is_final_switch_wb,
    output ie_pkg::ie_state_t state,
    output logic              ld_info_regs,
    output logic              packet_out_select,
    output logic              flush_pipe,
    output logic              ptc_clear,
    output logic              ld_eip,
    output logic              is_pop_eflags,
    output logic              is_servicing,
    output logic              is_switching,
    output logic              invalidate_fetch
);
    import ie_pkg::*;

    ie_state_t state_nxt;
    ie_state_t state_inc;  // following state in encoding order
    logic      final_q;    // final switch seen last cycle

    assign state_inc = ie_state_t'(state + STATE_W'(1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            final_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            final_q <= is_final_switch_wb;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (enable && ie_in)
                    state_nxt = FLUSH_IN;
            end
            FLUSH_IN, FLUSH_OUT: begin
                state_nxt = state_inc;  // flush never stalls
            end
            PUSH_CS, PUSH_EIP, PUSH_EFLAGS, LOAD_LO, LOAD_HI,
            XCHG, SAR, MOV_CS, JMP, RET_FAR, POP_EFLAGS: begin
                // hold the packet while the back end is full
                if (!rrag_stall)
                    state_nxt = state_inc;
            end
            WAIT_IN: begin
                if (final_q)
                    state_nxt = SERVICE;
            end
            SERVICE: begin
                if (is_iretd)
                    state_nxt = FLUSH_OUT;
            end
            WAIT_OUT: begin
                if (final_q)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    // outputs from state only
    always_comb begin
        packet_out_select = 1'b0;
        flush_pipe        = 1'b0;
        invalidate_fetch  = 1'b0;
        case (state)
            FLUSH_IN, FLUSH_OUT: begin
                flush_pipe = 1'b1;
            end
            PUSH_CS, PUSH_EIP, PUSH_EFLAGS, LOAD_LO, LOAD_HI,
            XCHG, SAR, MOV_CS, JMP, RET_FAR, POP_EFLAGS: begin
                packet_out_select = 1'b1;
            end
            WAIT_IN, WAIT_OUT: begin
                packet_out_select = 1'b1;  // fetch still muxed to us
                invalidate_fetch  = 1'b1;
            end
            default: begin
                packet_out_select = 1'b0;
            end
        endcase
    end

    assign ptc_clear     = flush_pipe;  // clears with every flush
    assign ld_info_regs  = (state == IDLE);
    assign ld_eip        = (state == IDLE) || (state == SERVICE);
    assign is_pop_eflags = (state == POP_EFLAGS);
    assign is_servicing  = (state != IDLE) && (state != FLUSH_IN);
    assign is_switching  = (state != IDLE) && (state != SERVICE);

endmodule

/* logic/ie_vector_calc.sv */
`timescale 1ns/1ps

module ie_vector_calc #(
    parameter ie_pkg::vector_t PROT_VECTOR = ie_pkg::DEF_PROT_VECTOR,
    parameter ie_pkg::vector_t PAGE_VECTOR = ie_pkg::DEF_PAGE_VECTOR,
    parameter ie_pkg::vector_t INTR_VECTOR = ie_pkg::DEF_INTR_VECTOR
) (
    input  logic             clk,
    input  logic             arst_n,
    input  ie_pkg::ie_type_t ie_type,
    input  ie_pkg::addr_t    idtr_base,
    input  ie_pkg::addr_t    eip_wb,
    input  ie_pkg::eflags_t  eflags_wb,
    input  ie_pkg::sel_t     cs_wb,
    input  logic             ld_info_regs,
    ie_ctx_if.source         ctx
);
    import ie_pkg::*;

    vector_t vector;
    addr_t   gate_off;
    addr_t   gate_addr;
    addr_t   gate_addr4;

    // lowest set type bit wins
    always_comb begin
        if (ie_type[0])
            vector = PROT_VECTOR;
        else if (ie_type[1])
            vector = PAGE_VECTOR;
        else if (ie_type[2])
            vector = INTR_VECTOR;
        else
            vector = '0;  // unused when no event
    end

    assign gate_off   = {{(ADDR_W-VECTOR_W-3){1'b0}}, vector, 3'b000};  // 8 bytes per gate
    assign gate_addr  = idtr_base + gate_off;
    assign gate_addr4 = gate_addr + addr_t'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctx.idt_entry  <= '0;
            ctx.idt_entry4 <= '0;
            ctx.eflags     <= '0;
            ctx.cs         <= '0;
            ctx.eip        <= '0;
        end else if (ld_info_regs) begin  // tracks wb while idle
            ctx.idt_entry  <= gate_addr;
            ctx.idt_entry4 <= gate_addr4;
            ctx.eflags     <= eflags_wb;
            ctx.cs         <= cs_wb;
            ctx.eip        <= eip_wb;
        end
    end

endmodule

/* logic/ie_ctx_if.sv */
`timescale 1ns/1ps

interface ie_ctx_if;
    import ie_pkg::*;

    addr_t   idt_entry;   // gate low dword
    addr_t   idt_entry4;  // gate high dword
    eflags_t eflags;
    sel_t    cs;
    addr_t   eip;         // faulting eip

    modport source (
        output idt_entry, idt_entry4, eflags, cs, eip
    );

    modport sink (
        input idt_entry, idt_entry4, eflags, cs, eip
    );

endinterface

/* logic/ie_pkg.sv */
package ie_pkg;

    localparam int ADDR_W   = 32;
    localparam int EFLAGS_W = 18;
    localparam int SEL_W    = 16;
    localparam int VECTOR_W = 8;
    localparam int PKT_W    = 128;
    localparam int STATE_W  = 5;

    typedef logic [ADDR_W-1:0]   addr_t;    // linear address
    typedef logic [EFLAGS_W-1:0] eflags_t;
    typedef logic [SEL_W-1:0]    sel_t;     // code segment selector
    typedef logic [2:0]          ie_type_t; // [0] prot, [1] page, [2] intr
    typedef logic [VECTOR_W-1:0] vector_t;
    typedef logic [PKT_W-1:0]    packet_t;  // first opcode byte in msb

    // default IDT vectors
    localparam vector_t DEF_PROT_VECTOR = 8'd13;
    localparam vector_t DEF_PAGE_VECTOR = 8'd14;
    localparam vector_t DEF_INTR_VECTOR = 8'd15;

    // opcode prefixes
    localparam logic [7:0]  OP_PUSH_IMM = 8'h68;
    localparam logic [15:0] OP_MOV_ECX  = 16'h8b0d;  // mov ecx, [m32]
    localparam logic [15:0] OP_MOV_EDX  = 16'h8b15;  // mov edx, [m32]
    localparam logic [23:0] OP_XCHG     = 24'h6687d1;
    localparam logic [23:0] OP_SAR      = 24'hc1f904; // sar ecx, 4
    localparam logic [23:0] OP_MOV_CS   = 24'h668ec9;
    localparam logic [15:0] OP_JMP      = 16'hffe2;   // jmp edx
    localparam logic [7:0]  OP_RET_FAR  = 8'hcb;
    localparam logic [7:0]  OP_POP      = 8'h59;

    // sequential encoding lets the sequencer step by +1
    typedef enum logic [STATE_W-1:0] {
        IDLE, FLUSH_IN,
        PUSH_CS, PUSH_EIP, PUSH_EFLAGS,
        LOAD_LO, LOAD_HI, XCHG, SAR, MOV_CS, JMP,
        WAIT_IN, SERVICE,
        FLUSH_OUT, RET_FAR, POP_EFLAGS, WAIT_OUT
    } ie_state_t;

endpackage
